// ==== src/rv_pkg.sv ====
// rv64 core shared definitions
// widths, word types, opcode and funct encodings, immediate extraction
package rv_pkg;

  // datapath and instruction widths
  localparam int xlen         = 64;
  localparam int inst_width   = 32;
  localparam int reg_id_width = 5;

  typedef logic [xlen-1:0]         xword_t;
  typedef logic [inst_width-1:0]   inst_t;
  typedef logic [reg_id_width-1:0] reg_id_t;
  // one bit per byte of a 64-bit store
  typedef logic [xlen/8-1:0]       wmask_t;

  // major opcodes, inst[6:0]
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_system = 7'b1110011;

  // funct3 in inst[14:12], funct12 in inst[31:20]
  localparam logic [2:0]  f3_addi    = 3'b000;
  localparam logic [2:0]  f3_sd      = 3'b011;
  localparam logic [11:0] f12_ebreak = 12'h001;

  // i-type, inst[31:20]
  function automatic xword_t imm_i(inst_t inst);
    return {{52{inst[31]}}, inst[31:20]};
  endfunction

  // s-type, split across inst[31:25] and inst[11:7]
  function automatic xword_t imm_s(inst_t inst);
    return {{52{inst[31]}}, inst[31:25], inst[11:7]};
  endfunction

  // u-type, upper 20 bits, low 12 cleared
  function automatic xword_t imm_u(inst_t inst);
    return {{32{inst[31]}}, inst[31:12], 12'b0};
  endfunction

  // j-type, scrambled offset with implicit zero lsb
  function automatic xword_t imm_j(inst_t inst);
    return {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

endpackage

// ==== src/rv_decoder.sv ====
// rv64 instruction decoder
// splits a word into register indices, immediate and control flags
`timescale 1ns/1ps

module rv_decoder (
  input  rv_pkg::inst_t   inst,
  output rv_pkg::reg_id_t rd,
  output rv_pkg::reg_id_t rs1,
  output rv_pkg::reg_id_t rs2,
  output rv_pkg::xword_t  imm,
  output logic            need_imm,
  output logic            alu_add,
  output logic            is_ebreak,
  output logic            is_auipc,
  output logic            is_jal,
  output logic            reg_wen,
  output logic            mem_wen,
  output logic            inst_not_ipl,
  output rv_pkg::wmask_t  wmask
);
  import rv_pkg::*;

  // raw fields
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [11:0] funct12;

  // opcode hits
  logic op_imm;
  logic op_auipc;
  logic op_jal;
  logic op_store;
  logic op_system;

  // recognised instructions
  logic dec_nop;
  logic dec_addi;
  logic dec_auipc;
  logic dec_jal;
  logic dec_sd;
  logic dec_ebreak;

  assign opcode  = inst[6:0];
  assign funct3  = inst[14:12];
  assign funct12 = inst[31:20];

  assign op_imm    = (opcode == opc_op_imm);
  assign op_auipc  = (opcode == opc_auipc);
  assign op_jal    = (opcode == opc_jal);
  assign op_store  = (opcode == opc_store);
  assign op_system = (opcode == opc_system);

  // the all-zero word is treated as a nop, not an illegal opcode
  assign dec_nop    = (inst == '0);
  assign dec_addi   = op_imm & (funct3 == f3_addi);
  assign dec_auipc  = op_auipc;
  assign dec_jal    = op_jal;
  assign dec_sd     = op_store & (funct3 == f3_sd);
  assign dec_ebreak = op_system & (funct3 == 3'b000) & (funct12 == f12_ebreak);

  // register fields sit at fixed positions for every format
  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // immediate format chosen by instruction type
  always_comb begin
    imm = '0;
    if (op_imm) begin
      imm = imm_i(inst);
    end else if (dec_auipc) begin
      imm = imm_u(inst);
    end else if (dec_jal) begin
      imm = imm_j(inst);
    end else if (dec_sd) begin
      imm = imm_s(inst);
    end
  end

  // addi, auipc and sd address all go through the adder
  assign alu_add  = dec_addi | dec_auipc | dec_sd;
  // second operand is the immediate for every adder user here
  assign need_imm = dec_addi | dec_auipc | dec_sd;

  assign is_ebreak = dec_ebreak;
  assign is_auipc  = dec_auipc;
  assign is_jal    = dec_jal;

  // only instructions with a destination write the register file
  assign reg_wen = dec_addi | dec_auipc | dec_jal;
  assign mem_wen = dec_sd;
  // sd writes all eight bytes
  assign wmask   = dec_sd ? '1 : '0;

  // anything outside the six known encodings
  assign inst_not_ipl = ~(dec_nop | dec_addi | dec_auipc | dec_jal | dec_sd | dec_ebreak);

endmodule

// ==== src/rv_regfile.sv ====
// integer register file, 32 x 64
// two asynchronous read ports, one write port, x0 reads as zero
`timescale 1ns/1ps

module rv_regfile (
  input  logic            clk,
  input  logic            rst_n,
  input  rv_pkg::reg_id_t rs1,
  input  rv_pkg::reg_id_t rs2,
  output rv_pkg::xword_t  rs1_data,
  output rv_pkg::xword_t  rs2_data,
  input  logic            wen,
  input  rv_pkg::reg_id_t rd,
  input  rv_pkg::xword_t  wdata
);
  import rv_pkg::*;

  // architectural registers
  xword_t regs [32];

  // x0 is never written, so its entry stays at the reset value
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      regs <= '{default: '0};
    end else if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // combinational reads
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 holds zero across every write the core issues
  a_x0_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rs1 == '0) |-> (rs1_data == '0)
  );

endmodule

// ==== src/rv_fetch.sv ====
// fetch stage, owns the pc and the instruction handshake
// stops for good after ebreak or an unimplemented word
`timescale 1ns/1ps

module rv_fetch #(
  parameter rv_pkg::xword_t reset_pc = '0
) (
  input  logic           clk,
  input  logic           rst_n,
  output rv_pkg::xword_t pc,
  input  logic           inst_valid,
  output logic           inst_ready,
  input  logic           stall,
  input  rv_pkg::xword_t next_pc,
  input  logic           is_ebreak,
  input  logic           inst_not_ipl,
  output logic           active,
  output logic           fire,
  output logic           halted,
  output logic           bad_inst
);
  import rv_pkg::*;

  xword_t pc_q;
  // low during reset and in the cycle after, keeps ready off until then
  logic   run_q;
  logic   halted_q;
  logic   bad_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q     <= reset_pc;
      run_q    <= 1'b0;
      halted_q <= 1'b0;
      bad_q    <= 1'b0;
    end else begin
      run_q <= 1'b1;
      // every architectural update happens on the handshake edge
      if (fire) begin
        pc_q     <= next_pc;
        halted_q <= is_ebreak;
        bad_q    <= inst_not_ipl;
      end
    end
  end

  // running and not stopped
  assign active = run_q & ~halted_q & ~bad_q;

  // a pending store holds the handshake off
  assign inst_ready = active & ~stall;
  assign fire       = inst_ready & inst_valid;

  assign pc       = pc_q;
  assign halted   = halted_q;
  assign bad_inst = bad_q;

  // jal targets and reset_pc must keep the pc on a word boundary
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    pc_q[1:0] == 2'b00
  );

endmodule

// ==== src/rv_exec.sv ====
// execute stage, adder, jal link and target, writeback select
// also drives the store request and its back-pressure
`timescale 1ns/1ps

module rv_exec (
  input  logic           clk,
  input  logic           rst_n,
  input  rv_pkg::xword_t pc,
  input  rv_pkg::xword_t imm,
  input  rv_pkg::xword_t rs1_data,
  input  rv_pkg::xword_t rs2_data,
  input  logic           need_imm,
  input  logic           alu_add,
  input  logic           is_auipc,
  input  logic           is_jal,
  input  logic           reg_wen,
  input  logic           mem_wen,
  input  logic           inst_not_ipl,
  input  rv_pkg::wmask_t wmask,
  input  logic           fire,
  input  logic           inst_valid,
  input  logic           active,
  output logic           rf_wen,
  output rv_pkg::xword_t rf_wdata,
  output rv_pkg::xword_t next_pc,
  output logic           stall,
  output logic           mem_valid,
  output rv_pkg::xword_t mem_addr,
  output rv_pkg::xword_t mem_wdata,
  output rv_pkg::wmask_t mem_wmask,
  input  logic           mem_ready
);
  import rv_pkg::*;

  xword_t op_a;
  xword_t op_b;
  xword_t alu_res;
  xword_t pc_plus4;
  xword_t jal_target;

  // auipc adds to the pc, everything else to rs1
  assign op_a = is_auipc ? pc : rs1_data;
  assign op_b = need_imm ? imm : rs2_data;

  assign alu_res = alu_add ? (op_a + op_b) : '0;

  // sequential and jump targets
  assign pc_plus4   = pc + xword_t'(4);
  assign jal_target = pc + imm;
  assign next_pc    = is_jal ? jal_target : pc_plus4;

  // jal links the return address, others take the adder
  assign rf_wdata = is_jal ? pc_plus4 : alu_res;
  // write only on the handshake and never for an unknown word
  assign rf_wen   = reg_wen & fire & ~inst_not_ipl;

  // store is offered while the sd sits on the instruction port
  assign mem_valid = mem_wen & active & inst_valid;
  assign mem_addr  = alu_res;
  assign mem_wdata = rs2_data;
  assign mem_wmask = wmask;

  // hold the handshake until the store is taken
  assign stall = mem_wen & active & inst_valid & ~mem_ready;

  // a stalled store keeps its payload, relies on fetch and regfile holding
  a_store_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (mem_valid && !mem_ready) ##1 mem_valid |-> $stable(mem_wdata) && $stable(mem_addr)
  );

endmodule

// ==== src/rv_core_top.sv ====
// rv64 integer core top level
// fetch, decoder, register file and execute wired to the external ports
`timescale 1ns/1ps

module rv_core_top #(
  parameter rv_pkg::xword_t reset_pc = '0
) (
  input  logic           clk,
  input  logic           rst_n,
  // instruction port
  output rv_pkg::xword_t pc,
  output logic           inst_ready,
  input  logic           inst_valid,
  input  rv_pkg::inst_t  inst,
  // data port, stores only
  output logic           mem_valid,
  output rv_pkg::xword_t mem_addr,
  output rv_pkg::xword_t mem_wdata,
  output rv_pkg::wmask_t mem_wmask,
  input  logic           mem_ready,
  // sticky stop status
  output logic           halted,
  output logic           bad_inst
);
  import rv_pkg::*;

  // decoder outputs
  reg_id_t rd;
  reg_id_t rs1;
  reg_id_t rs2;
  xword_t  imm;
  logic    need_imm;
  logic    alu_add;
  logic    is_ebreak;
  logic    is_auipc;
  logic    is_jal;
  logic    reg_wen;
  logic    mem_wen;
  logic    inst_not_ipl;
  wmask_t  wmask;

  // register file read data
  xword_t  rs1_data;
  xword_t  rs2_data;

  // writeback and control between exec and fetch
  logic    rf_wen;
  xword_t  rf_wdata;
  xword_t  next_pc;
  logic    stall;
  logic    fire;
  logic    active;

  rv_fetch #(
    .reset_pc (reset_pc)
  ) u_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc           (pc),
    .inst_valid   (inst_valid),
    .inst_ready   (inst_ready),
    .stall        (stall),
    .next_pc      (next_pc),
    .is_ebreak    (is_ebreak),
    .inst_not_ipl (inst_not_ipl),
    .active       (active),
    .fire         (fire),
    .halted       (halted),
    .bad_inst     (bad_inst)
  );

  // decodes whatever word is on the port, fire qualifies its use
  rv_decoder u_decoder (
    .inst         (inst),
    .rd           (rd),
    .rs1          (rs1),
    .rs2          (rs2),
    .imm          (imm),
    .need_imm     (need_imm),
    .alu_add      (alu_add),
    .is_ebreak    (is_ebreak),
    .is_auipc     (is_auipc),
    .is_jal       (is_jal),
    .reg_wen      (reg_wen),
    .mem_wen      (mem_wen),
    .inst_not_ipl (inst_not_ipl),
    .wmask        (wmask)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (rf_wen),
    .rd       (rd),
    .wdata    (rf_wdata)
  );

  rv_exec u_exec (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc           (pc),
    .imm          (imm),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .need_imm     (need_imm),
    .alu_add      (alu_add),
    .is_auipc     (is_auipc),
    .is_jal       (is_jal),
    .reg_wen      (reg_wen),
    .mem_wen      (mem_wen),
    .inst_not_ipl (inst_not_ipl),
    .wmask        (wmask),
    .fire         (fire),
    .inst_valid   (inst_valid),
    .active       (active),
    .rf_wen       (rf_wen),
    .rf_wdata     (rf_wdata),
    .next_pc      (next_pc),
    .stall        (stall),
    .mem_valid    (mem_valid),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_wmask    (mem_wmask),
    .mem_ready    (mem_ready)
  );

endmodule

// ==== verif/rv_tb_prog.svh ====
// rv64 core testbench helpers
// lfsr, instruction encoders, program builder and reference register model
`ifndef RV_TB_PROG_SVH
`define RV_TB_PROG_SVH

// instruction kinds kept beside each program word
localparam int k_nop    = 0;
localparam int k_addi   = 1;
localparam int k_auipc  = 2;
localparam int k_jal    = 3;
localparam int k_sd     = 4;
localparam int k_ebreak = 5;
localparam int k_bad    = 6;
localparam int prog_depth = 64;

// 16-bit fibonacci lfsr, taps 16 14 13 11
logic [15:0] lfsr_q = 16'd34931;

function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
  lfsr_q = {lfsr_q[14:0], fb};
  return fb;
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

// encoders, field layout from the isa
function automatic inst_t enc_addi(reg_id_t rd, reg_id_t rs1, logic [11:0] imm);
  return {imm, rs1, f3_addi, rd, opc_op_imm};
endfunction

function automatic inst_t enc_auipc(reg_id_t rd, logic [19:0] imm);
  return {imm, rd, opc_auipc};
endfunction

function automatic inst_t enc_sd(reg_id_t rs1, reg_id_t rs2, logic [11:0] imm);
  return {imm[11:5], rs2, rs1, f3_sd, imm[4:0], opc_store};
endfunction

function automatic inst_t enc_jal(reg_id_t rd, logic [20:0] imm);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
endfunction

// program image and its reference view
inst_t   prog      [prog_depth];
int      prog_kind [prog_depth];
reg_id_t prog_rd   [prog_depth];
reg_id_t prog_rs1  [prog_depth];
reg_id_t prog_rs2  [prog_depth];
xword_t  prog_imm  [prog_depth];
int      prog_len;

task automatic clear_program();
  for (int i = 0; i < prog_depth; i++) begin
    prog[i]      = '0;
    prog_kind[i] = k_nop;
    prog_rd[i]   = '0;
    prog_rs1[i]  = '0;
    prog_rs2[i]  = '0;
    prog_imm[i]  = '0;
  end
  prog_len = 0;
endtask

task automatic add_word(inst_t w, int kind, reg_id_t rd, reg_id_t rs1, reg_id_t rs2,
                        xword_t imm);
  prog[prog_len]      = w;
  prog_kind[prog_len] = kind;
  prog_rd[prog_len]   = rd;
  prog_rs1[prog_len]  = rs1;
  prog_rs2[prog_len]  = rs2;
  prog_imm[prog_len]  = imm;
  prog_len++;
endtask

// reference model state
xword_t m_regs [32];
xword_t m_pc;
logic   m_halted;
logic   m_bad;

task automatic model_reset();
  for (int i = 0; i < 32; i++) begin
    m_regs[i] = '0;
  end
  m_pc     = tb_reset_pc;
  m_halted = 1'b0;
  m_bad    = 1'b0;
endtask

// one accepted instruction, architectural rules only
task automatic model_step();
  int     idx;
  xword_t link;
  idx  = int'((m_pc - tb_reset_pc) >> 2);
  link = m_pc + 64'd4;
  case (prog_kind[idx])
    k_addi: begin
      if (prog_rd[idx] != 0) m_regs[prog_rd[idx]] = m_regs[prog_rs1[idx]] + prog_imm[idx];
    end
    k_auipc: begin
      if (prog_rd[idx] != 0) m_regs[prog_rd[idx]] = m_pc + prog_imm[idx];
    end
    k_jal: begin
      if (prog_rd[idx] != 0) m_regs[prog_rd[idx]] = link;
      link = m_pc + prog_imm[idx];
    end
    k_ebreak: m_halted = 1'b1;
    k_bad:    m_bad = 1'b1;
    default: ;
  endcase
  m_pc = link;
endtask

`endif

// ==== verif/rv_core_tb.sv ====
// rv64 core testbench
// random programs against a reference model, checked by concurrent assertions
`timescale 1ns/1ps

module rv_core_tb;
  import rv_pkg::*;

  localparam xword_t tb_reset_pc = 64'h1000;
  localparam int     clk_period  = 40;
  // run one plus run two program words
  localparam int     total_words = 60;

  logic   clk;
  logic   rst_n;
  xword_t pc;
  logic   inst_ready;
  logic   inst_valid;
  inst_t  inst;
  logic   mem_valid;
  xword_t mem_addr;
  xword_t mem_wdata;
  wmask_t mem_wmask;
  logic   mem_ready;
  logic   halted;
  logic   bad_inst;

  `include "rv_tb_prog.svh"

  rv_core_top #(
    .reset_pc (tb_reset_pc)
  ) dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc),
    .inst_ready (inst_ready),
    .inst_valid (inst_valid),
    .inst       (inst),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wmask  (mem_wmask),
    .mem_ready  (mem_ready),
    .halted     (halted),
    .bad_inst   (bad_inst)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic report_error(string msg);
    $display("Error: %0t ns: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // expected view of the word the model says is current
  int     cur_idx;
  int     cur_kind;
  xword_t exp_addr;
  xword_t exp_data;
  logic   fire_tb;

  always_comb begin
    cur_idx  = int'((m_pc - tb_reset_pc) >> 2);
    cur_kind = (cur_idx < prog_depth) ? prog_kind[cur_idx] : k_nop;
    exp_addr = m_regs[prog_rs1[cur_idx % prog_depth]] + prog_imm[cur_idx % prog_depth];
    exp_data = m_regs[prog_rs2[cur_idx % prog_depth]];
  end

  assign fire_tb = inst_valid & inst_ready;

  // memory models drive their outputs on the falling edge
  int ready_low;

  always @(negedge clk) begin
    if (!rst_n) begin
      inst_valid <= 1'b0;
      mem_ready  <= 1'b0;
      ready_low  = 0;
    end else begin
      // gap about one cycle in four
      inst_valid <= (rand_bits(2) != 0);
      inst       <= prog[int'((pc - tb_reset_pc) >> 2) % prog_depth];
      if (ready_low > 0) begin
        ready_low--;
        mem_ready <= 1'b0;
      end else if (rand_bits(2) == 0) begin
        // start a low stretch of one to eight cycles
        ready_low = rand_bits(3);
        mem_ready <= 1'b0;
      end else begin
        mem_ready <= 1'b1;
      end
    end
  end

  // model advances on each handshake
  always @(posedge clk) begin
    if (!rst_n) begin
      model_reset();
    end else if (fire_tb) begin
      model_step();
    end
  end

  a_reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> !inst_ready && !mem_valid && !halted && !bad_inst && pc == tb_reset_pc)
    else report_error("state after reset");

  a_pc: assert property (@(posedge clk) disable iff (!rst_n) pc == m_pc)
    else report_error("pc differs from model");

  a_flags: assert property (@(posedge clk) disable iff (!rst_n)
    halted == m_halted && bad_inst == m_bad)
    else report_error("halted or bad_inst differs from model");

  a_stopped: assert property (@(posedge clk) disable iff (!rst_n)
    (halted || bad_inst) |-> !inst_ready && !mem_valid)
    else report_error("activity after stop");

  a_store_value: assert property (@(posedge clk) disable iff (!rst_n)
    mem_valid |-> cur_kind == k_sd && mem_addr == exp_addr && mem_wdata == exp_data
                  && mem_wmask == 8'hff)
    else report_error("store address, data or mask differs from model");

  // each sd retires together with its single store
  a_store_once: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_valid && mem_ready) == (fire_tb && cur_kind == k_sd))
    else report_error("store and handshake out of step");

  a_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_valid && !mem_ready) |-> !inst_ready)
    else report_error("handshake open during store stall");

  // reset low across three rising edges
  task automatic apply_reset();
    @(negedge clk);
    rst_n <= 1'b0;
    repeat (3) @(negedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic build_run1();
    reg_id_t     rd;
    reg_id_t     rs1;
    logic [11:0] imm12;
    logic [19:0] imm20;
    clear_program();
    // random addi and auipc chain
    for (int i = 0; i < 20; i++) begin
      // the first word always targets x0
      rd = (i == 0) ? '0 : reg_id_t'(rand_bits(5));
      if (lfsr_bit()) begin
        rs1   = reg_id_t'(rand_bits(5));
        imm12 = 12'(rand_bits(12));
        add_word(enc_addi(rd, rs1, imm12), k_addi, rd, rs1, '0,
                 {{52{imm12[11]}}, imm12});
      end else begin
        imm20 = 20'(rand_bits(20));
        add_word(enc_auipc(rd, imm20), k_auipc, rd, '0, '0,
                 {{32{imm20[19]}}, imm20, 12'h0});
      end
    end
    // store every register, x0 included
    for (int r = 0; r < 32; r++) begin
      rs1   = reg_id_t'(rand_bits(5));
      imm12 = 12'(rand_bits(12));
      add_word(enc_sd(rs1, reg_id_t'(r), imm12), k_sd, '0, rs1, reg_id_t'(r),
               {{52{imm12[11]}}, imm12});
    end
    // jal over an add that must never be fetched
    add_word(enc_jal(5'd5, 21'd8), k_jal, 5'd5, '0, '0, 64'd8);
    add_word({7'd0, 5'd2, 5'd1, 3'd0, 5'd3, 7'b0110011}, k_bad, '0, '0, '0, '0);
    add_word(enc_sd(5'd0, 5'd5, 12'h040), k_sd, '0, 5'd0, 5'd5, 64'h40);
    add_word({f12_ebreak, 5'd0, 3'd0, 5'd0, opc_system}, k_ebreak, '0, '0, '0, '0);
  endtask

  task automatic build_run2();
    clear_program();
    add_word('0, k_nop, '0, '0, '0, '0);
    add_word(enc_addi(5'd7, 5'd0, 12'h055), k_addi, 5'd7, 5'd0, '0, 64'h55);
    add_word(enc_sd(5'd0, 5'd7, 12'h008), k_sd, '0, 5'd0, 5'd7, 64'h8);
    // add x3, x1, x2 is register-register and not implemented
    add_word({7'd0, 5'd2, 5'd1, 3'd0, 5'd3, 7'b0110011}, k_bad, '0, '0, '0, '0);
  endtask

  initial begin
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    mem_ready  = 1'b0;
    build_run1();
    apply_reset();
    wait (halted || bad_inst);
    repeat (10) @(posedge clk);
    if (!halted) report_error("first program did not end in halted");
    // the halted core ignores the new program until the fresh reset
    build_run2();
    apply_reset();
    wait (halted || bad_inst);
    repeat (10) @(posedge clk);
    if (bad_inst && !halted) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      report_error("second program did not end in bad_inst");
    end
  end

  // watchdog
  initial begin
    repeat (total_words * 40 * 4) @(posedge clk);
    $display("run timed out waiting for the core to stop");
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  end

endmodule

// ==== flist.f ====
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_fetch.sv
src/rv_exec.sv
src/rv_core_top.sv
+incdir+verif
verif/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - src/rv_pkg.sv
      - src/rv_decoder.sv
      - src/rv_regfile.sv
      - src/rv_fetch.sv
      - src/rv_exec.sv
      - src/rv_core_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/rv_core_tb.sv
